// ==== verif/mini_cpu_golden.txt ====
// layout: program word count, program words, trace entry count, then trace entries
// trace columns: pc, register number, write data (all hex)
0000001d
3c011234 34215678 2402fffb 24230010  // lui ori addiu addiu
00222021 00832823 00233024 00a23825  // addu subu and or
00264026 0045482a 00a2502a 00015900  // xor slt slt sll
304cff0f 398d00ff 24200001 fc220000  // andi xori then r0 write and unknown op
00017021 102e0002 240f0111 24100222  // read r0 then taken beq and two squashed
24110333 16200002 240f0444 24100555  // addiu then taken bne and two squashed
12200005 142e0005 26320001 02529821  // untaken beq bne then dependent pair
1000ffff                             // spin on beq to self
00000012
bfc00000 01 12340000
bfc00004 01 12345678
bfc00008 02 fffffffb
bfc0000c 03 12345688
bfc00010 04 12345673
bfc00014 05 ffffffeb
bfc00018 06 12345608
bfc0001c 07 fffffffb
bfc00020 08 00000070
bfc00024 09 00000000
bfc00028 0a 00000001
bfc0002c 0b 23456780
bfc00030 0c 0000ff0b
bfc00034 0d 0000fff4
bfc00040 0e 12345678
bfc00050 11 00000333
bfc00068 12 00000334
bfc0006c 13 00000668

// ==== mini_cpu.f ====
+incdir+source
source/mini_cpu_pkg.sv
source/fetch_stage.sv
source/decode_stage.sv
source/execute_stage.sv
source/mini_cpu_top.sv
verif/mini_cpu_checker.sv
verif/mini_cpu_tb.sv

// ==== verif/mini_cpu_tb.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// mini_cpu testbench
// instruction memory with wait states, golden trace compare
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`include "mini_cpu_config.svh"

module mini_cpu_tb;

    timeunit 1ns;
    timeprecision 100ps;

    localparam int TIMEOUT_CYCLES = 200;
    localparam int QUIET_CYCLES   = 50;           // watch for stray writes after the last entry

    logic        aclk;
    logic        rst_n;
    logic        inst_valid;
    logic [31:0] inst_rdata;
    logic [31:0] inst_addr;
    logic [31:0] debug_wb_pc;
    logic [31:0] debug_wb_rf_wdata;
    logic [3:0]  debug_wb_rf_wen;
    logic [4:0]  debug_wb_rf_wnum;

    logic [31:0] golden [0:255];                  // count, program, count, triples
    logic [31:0] rand_state;
    int          prog_words;
    int          exp_entries;
    int          errors;
    int          timeouts;
    bit          loaded;

    mini_cpu_top UUT (
        .aclk              (aclk),
        .rst_n             (rst_n),
        .inst_valid        (inst_valid),
        .inst_rdata        (inst_rdata),
        .inst_addr         (inst_addr),
        .debug_wb_pc       (debug_wb_pc),
        .debug_wb_rf_wdata (debug_wb_rf_wdata),
        .debug_wb_rf_wen   (debug_wb_rf_wen),
        .debug_wb_rf_wnum  (debug_wb_rf_wnum)
    );

    always #4 aclk = ~aclk;

    function automatic logic [31:0] lcg_next(input logic [31:0] state);
        return state * 32'd1664525 + 32'd1013904223;
    endfunction

    function automatic logic [31:0] fetch_word(input logic [31:0] addr);
        logic [31:0] index;
        index = (addr - `MINI_CPU_RESET_PC) >> 2;
        if (index < prog_words) begin
            return golden[1 + index];
        end
        return 32'h0000_0000;                     // sll r0 past the program end
    endfunction

    // memory model, roughly one cycle in three not ready
    always @(negedge aclk) begin
        rand_state = lcg_next(rand_state);
        inst_valid <= (rand_state[31:16] % 3) != 0;
        inst_rdata <= fetch_word(inst_addr);
    end

    task automatic load_golden(output bit ok);
        $readmemh("verif/mini_cpu_golden.txt", golden);
        ok = !$isunknown(golden[0]) && golden[0] > 0 && golden[0] < 128;
        if (ok) begin
            prog_words  = golden[0];
            exp_entries = golden[prog_words + 1];
            ok          = !$isunknown(golden[prog_words + 1]);
        end
        if (!ok) begin
            $display("golden file verif/mini_cpu_golden.txt is missing or malformed");
            errors++;
        end
    endtask

    task automatic wait_retire(output bit seen);
        int cycles;
        seen   = 1'b0;
        cycles = 0;
        while (!seen && cycles < TIMEOUT_CYCLES) begin
            @(negedge aclk);
            cycles++;
            if (debug_wb_rf_wen == 4'b1111) seen = 1'b1;
        end
    endtask

    task automatic compare_trace();
        int          i;
        int          at;
        bit          seen;
        for (i = 0; i < exp_entries; i++) begin
            at = prog_words + 2 + 3 * i;
            wait_retire(seen);
            if (!seen) begin
                $display("timeout: trace entry %0d for pc %h never arrived in %0d cycles",
                         i, golden[at], TIMEOUT_CYCLES);
                timeouts++;
                break;
            end
            if (debug_wb_pc !== golden[at]) begin
                errors++;
                $display("ERR %0t: entry %0d debug_wb_pc got %h expected %h",
                         $time, i, debug_wb_pc, golden[at]);
            end
            if (debug_wb_rf_wnum !== golden[at + 1][4:0]) begin
                errors++;
                $display("ERR %0t: entry %0d debug_wb_rf_wnum got %0d expected %0d",
                         $time, i, debug_wb_rf_wnum, golden[at + 1][4:0]);
            end
            if (debug_wb_rf_wdata !== golden[at + 2]) begin
                errors++;
                $display("ERR %0t: entry %0d debug_wb_rf_wdata got %h expected %h",
                         $time, i, debug_wb_rf_wdata, golden[at + 2]);
            end
        end
    endtask

    task automatic check_quiet();
        int cycles;
        for (cycles = 0; cycles < QUIET_CYCLES; cycles++) begin
            @(negedge aclk);
            if (debug_wb_rf_wen !== 4'b0000) begin
                errors++;
                $display("ERR %0t: extra write-back pc %h reg %0d data %h",
                         $time, debug_wb_pc, debug_wb_rf_wnum, debug_wb_rf_wdata);
            end
        end
    endtask

    initial begin
        aclk       = 1'b0;
        rst_n      = 1'b0;
        inst_valid = 1'b0;
        inst_rdata = 32'h0000_0000;
        rand_state = 32'h9e06_9328;
        errors     = 0;
        timeouts   = 0;
        load_golden(loaded);
        repeat (2) @(negedge aclk);
        rst_n = 1'b1;
        if (loaded) begin
            compare_trace();
            if (timeouts == 0) check_quiet();   // spin loop must retire nothing
        end
        $display("trace compare done: %0d errors, %0d timeouts", errors, timeouts);
        if (errors == 0 && timeouts == 0) begin
            $display("*** TEST PASSED ***");
        end else begin
            $display("*** TEST FAILED ***");
        end
        $finish;
    end

endmodule

// ==== verif/mini_cpu_checker.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// mini_cpu port checker
// assertions on fetch address and debug trace
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`include "mini_cpu_config.svh"

module mini_cpu_checker (
    input logic        aclk,
    input logic        rst_n,
    input logic [31:0] inst_addr,
    input logic [3:0]  debug_wb_rf_wen,
    input logic [4:0]  debug_wb_rf_wnum
);

    timeunit 1ns;
    timeprecision 100ps;

    wen_all_or_none: assert property (@(posedge aclk) disable iff (!rst_n)
        debug_wb_rf_wen == 4'b0000 || debug_wb_rf_wen == 4'b1111)
        else $error("debug_wb_rf_wen partially set");

    wnum_nonzero: assert property (@(posedge aclk) disable iff (!rst_n)
        debug_wb_rf_wen == 4'b1111 |-> debug_wb_rf_wnum != 5'd0)
        else $error("write-back to register zero on the trace port");

    addr_aligned: assert property (@(posedge aclk) disable iff (!rst_n)
        inst_addr[1:0] == 2'b00)
        else $error("inst_addr not word aligned");

    // first edge after reset release
    boot_vector: assert property (@(posedge aclk) $rose(rst_n) |-> inst_addr == `MINI_CPU_RESET_PC)
        else $error("inst_addr not at reset vector after reset");

endmodule

bind mini_cpu_top mini_cpu_checker u_checker (
    .aclk             (aclk),
    .rst_n            (rst_n),
    .inst_addr        (inst_addr),
    .debug_wb_rf_wen  (debug_wb_rf_wen),
    .debug_wb_rf_wnum (debug_wb_rf_wnum)
);

// ==== source/mini_cpu_top.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// mini_cpu top level
// stage wiring and write-back debug trace
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`include "mini_cpu_config.svh"

module mini_cpu_top (
    input  logic                      aclk,
    input  logic                      rst_n,
    input  logic                      inst_valid,
    input  logic [31:0]               inst_rdata,
    output logic [`MINI_CPU_XLEN-1:0] inst_addr,
    output logic [`MINI_CPU_XLEN-1:0] debug_wb_pc,
    output logic [`MINI_CPU_XLEN-1:0] debug_wb_rf_wdata,
    output logic [3:0]                debug_wb_rf_wen,
    output logic [4:0]                debug_wb_rf_wnum
);

    mini_cpu_pkg::if_id_t    if_id;        // fetch -> decode
    mini_cpu_pkg::id_exe_t   id_exe;       // decode -> execute
    mini_cpu_pkg::exe_wb_t   exe_wb;       // execute -> regfile write, debug
    mini_cpu_pkg::redirect_t redirect;     // taken branch, to fetch and decode

    assign debug_wb_pc       = exe_wb.pc;
    assign debug_wb_rf_wdata = exe_wb.result;
    assign debug_wb_rf_wen   = (exe_wb.valid && exe_wb.rf_wr) ? 4'b1111 : 4'b0000;
    assign debug_wb_rf_wnum  = exe_wb.dst;

    fetch_stage u_fetch (
        .aclk       (aclk),
        .rst_n      (rst_n),
        .inst_valid (inst_valid),
        .inst_rdata (inst_rdata),
        .redirect   (redirect),
        .inst_addr  (inst_addr),
        .if_id      (if_id)
    );

    decode_stage u_decode (
        .aclk     (aclk),
        .rst_n    (rst_n),
        .if_id    (if_id),
        .exe_wb   (exe_wb),
        .redirect (redirect),
        .id_exe   (id_exe)
    );

    execute_stage u_execute (
        .aclk     (aclk),
        .rst_n    (rst_n),
        .id_exe   (id_exe),
        .exe_wb   (exe_wb),
        .redirect (redirect)
    );

endmodule

// ==== source/execute_stage.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// execute stage
// forwarding, ALU, branch resolve, exe/wb register
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`include "mini_cpu_config.svh"

module execute_stage (
    input  logic                    aclk,
    input  logic                    rst_n,
    input  mini_cpu_pkg::id_exe_t   id_exe,
    output mini_cpu_pkg::exe_wb_t   exe_wb,
    output mini_cpu_pkg::redirect_t redirect
);

    logic                      wb_fwd;
    logic [`MINI_CPU_XLEN-1:0] src_a;
    logic [`MINI_CPU_XLEN-1:0] src_t;
    logic [`MINI_CPU_XLEN-1:0] src_b;
    logic [`MINI_CPU_XLEN-1:0] alu_out;
    logic                      equal;
    logic                      br_hit;
    mini_cpu_pkg::exe_wb_t     nxt;
    mini_cpu_pkg::exe_wb_t     entry_q;
    logic                      valid_q;

    // write-back entry bypasses the values read in decode
    assign wb_fwd = exe_wb.valid && exe_wb.rf_wr;    // rf_wr already clear for r0

    assign src_a = (wb_fwd && exe_wb.dst == id_exe.rs) ? exe_wb.result : id_exe.rs_val;
    assign src_t = (wb_fwd && exe_wb.dst == id_exe.rt) ? exe_wb.result : id_exe.rt_val;
    assign src_b = id_exe.use_imm ? id_exe.imm32 : src_t;

    always_comb begin
        case (id_exe.alu_op)
            mini_cpu_pkg::alu_add: alu_out = src_a + src_b;
            mini_cpu_pkg::alu_sub: alu_out = src_a - src_b;
            mini_cpu_pkg::alu_and: alu_out = src_a & src_b;
            mini_cpu_pkg::alu_or:  alu_out = src_a | src_b;
            mini_cpu_pkg::alu_xor: alu_out = src_a ^ src_b;
            mini_cpu_pkg::alu_slt: alu_out = {31'd0, $signed(src_a) < $signed(src_b)};
            mini_cpu_pkg::alu_sll: alu_out = src_b << id_exe.shamt;
            mini_cpu_pkg::alu_lui: alu_out = {src_b[15:0], 16'h0000};
            default:               alu_out = '0;
        endcase
    end

    assign equal = (src_a == src_t);

    always_comb begin
        case (id_exe.branch)
            mini_cpu_pkg::br_beq: br_hit = equal;
            mini_cpu_pkg::br_bne: br_hit = !equal;
            default:              br_hit = 1'b0;
        endcase
    end

    // no delay slot, target is relative to the branch's own pc+4
    assign redirect.taken  = id_exe.valid && br_hit;
    assign redirect.target = id_exe.pc + `MINI_CPU_XLEN'd4 + id_exe.imm32;

    assign nxt = '{
        valid:  id_exe.valid,
        pc:     id_exe.pc,
        dst:    id_exe.dst,
        rf_wr:  id_exe.rf_wr,
        result: alu_out
    };

    always_ff @(posedge aclk or negedge rst_n) begin
        if (!rst_n) begin
            valid_q <= 1'b0;
        end else begin
            valid_q <= nxt.valid;
        end
    end

    always_ff @(posedge aclk) begin
        entry_q <= nxt;
    end

    always_comb begin
        exe_wb       = entry_q;
        exe_wb.valid = valid_q;
    end

endmodule

// ==== source/decode_stage.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// decode stage
// decoder, register file, decode/execute register
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`include "mini_cpu_config.svh"

module decode_stage (
    input  logic                    aclk,
    input  logic                    rst_n,
    input  mini_cpu_pkg::if_id_t    if_id,
    input  mini_cpu_pkg::exe_wb_t   exe_wb,
    input  mini_cpu_pkg::redirect_t redirect,
    output mini_cpu_pkg::id_exe_t   id_exe
);

    logic [`MINI_CPU_XLEN-1:0] regs [32];
    logic [5:0]                opcode;
    logic [5:0]                funct;
    logic [4:0]                rs;
    logic [4:0]                rt;
    logic [4:0]                rd;
    logic [15:0]               imm16;
    logic                      wb_wr;
    logic                      dec_wr;
    mini_cpu_pkg::id_exe_t     dec;
    mini_cpu_pkg::id_exe_t     entry_q;
    logic                      valid_q;

    assign opcode = if_id.inst[31:26];
    assign rs     = if_id.inst[25:21];
    assign rt     = if_id.inst[20:16];
    assign rd     = if_id.inst[15:11];
    assign funct  = if_id.inst[5:0];
    assign imm16  = if_id.inst[15:0];

    assign wb_wr = exe_wb.valid && exe_wb.rf_wr;    // dst is never zero here

    always_ff @(posedge aclk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (wb_wr) begin
            regs[exe_wb.dst] <= exe_wb.result;
        end
    end

    always_comb begin
        dec         = '0;
        dec.pc      = if_id.pc;
        dec.rs      = rs;
        dec.rt      = rt;
        dec.shamt   = if_id.inst[10:6];
        dec.alu_op  = mini_cpu_pkg::alu_none;
        dec.branch  = mini_cpu_pkg::br_none;
        dec.imm32   = {{16{imm16[15]}}, imm16};     // sign extended by default
        dec.dst     = rt;
        dec_wr      = 1'b0;
        // operand read with write-through from write-back
        dec.rs_val  = (wb_wr && exe_wb.dst == rs) ? exe_wb.result : regs[rs];
        dec.rt_val  = (wb_wr && exe_wb.dst == rt) ? exe_wb.result : regs[rt];
        case (opcode)
            6'h00: begin
                dec.dst = rd;
                dec_wr  = 1'b1;
                case (funct)
                    6'h21:   dec.alu_op = mini_cpu_pkg::alu_add;
                    6'h23:   dec.alu_op = mini_cpu_pkg::alu_sub;
                    6'h24:   dec.alu_op = mini_cpu_pkg::alu_and;
                    6'h25:   dec.alu_op = mini_cpu_pkg::alu_or;
                    6'h26:   dec.alu_op = mini_cpu_pkg::alu_xor;
                    6'h2a:   dec.alu_op = mini_cpu_pkg::alu_slt;
                    6'h00:   dec.alu_op = mini_cpu_pkg::alu_sll;
                    default: dec_wr     = 1'b0;     // unsupported funct retires as nop
                endcase
            end
            6'h04, 6'h05: begin
                dec.branch = (opcode == 6'h04) ? mini_cpu_pkg::br_beq : mini_cpu_pkg::br_bne;
                dec.imm32  = {{14{imm16[15]}}, imm16, 2'b00};
            end
            6'h09: begin
                dec.alu_op  = mini_cpu_pkg::alu_add;    // addiu
                dec.use_imm = 1'b1;
                dec_wr      = 1'b1;
            end
            6'h0c, 6'h0d, 6'h0e, 6'h0f: begin
                dec.imm32   = {16'h0000, imm16};        // logical ops zero extend
                dec.use_imm = 1'b1;
                dec_wr      = 1'b1;
                case (opcode[1:0])
                    2'b00:   dec.alu_op = mini_cpu_pkg::alu_and;
                    2'b01:   dec.alu_op = mini_cpu_pkg::alu_or;
                    2'b10:   dec.alu_op = mini_cpu_pkg::alu_xor;
                    default: dec.alu_op = mini_cpu_pkg::alu_lui;
                endcase
            end
            default: ;
        endcase
        dec.rf_wr = dec_wr && (dec.dst != 5'd0);
        dec.valid = if_id.valid && !redirect.taken;    // squash on taken branch
    end

    always_ff @(posedge aclk or negedge rst_n) begin
        if (!rst_n) begin
            valid_q <= 1'b0;
        end else begin
            valid_q <= dec.valid;
        end
    end

    always_ff @(posedge aclk) begin
        entry_q <= dec;
    end

    always_comb begin
        id_exe       = entry_q;
        id_exe.valid = valid_q;
    end

endmodule

// ==== source/fetch_stage.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// fetch stage
// PC, next-PC select, fetch/decode register
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`include "mini_cpu_config.svh"

module fetch_stage (
    input  logic                      aclk,
    input  logic                      rst_n,
    input  logic                      inst_valid,
    input  logic [31:0]               inst_rdata,
    input  mini_cpu_pkg::redirect_t   redirect,
    output logic [`MINI_CPU_XLEN-1:0] inst_addr,
    output mini_cpu_pkg::if_id_t      if_id
);

    logic [`MINI_CPU_XLEN-1:0] pc;
    logic                      accept;
    mini_cpu_pkg::if_id_t      next_entry;
    mini_cpu_pkg::if_id_t      entry_q;
    logic                      valid_q;

    // word on the port belongs to a squashed path when a branch is taken
    assign accept = inst_valid && !redirect.taken;

    always_ff @(posedge aclk or negedge rst_n) begin
        if (!rst_n) begin
            pc <= `MINI_CPU_RESET_PC;
        end else if (redirect.taken) begin
            pc <= redirect.target;                // branch wins over a pending fetch
        end else if (inst_valid) begin
            pc <= pc + `MINI_CPU_XLEN'd4;
        end
    end

    assign inst_addr = pc;

    assign next_entry = '{valid: accept, pc: pc, inst: inst_rdata};

    always_ff @(posedge aclk or negedge rst_n) begin
        if (!rst_n) begin
            valid_q <= 1'b0;
        end else begin
            valid_q <= next_entry.valid;          // bubble on stall or squash
        end
    end

    always_ff @(posedge aclk) begin
        entry_q <= next_entry;
    end

    always_comb begin
        if_id       = entry_q;
        if_id.valid = valid_q;
    end

endmodule

// ==== source/mini_cpu_pkg.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// mini_cpu package
// ALU/branch encodings and stage structs
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`include "mini_cpu_config.svh"

package mini_cpu_pkg;

    typedef enum logic [3:0] {
        alu_add,
        alu_sub,
        alu_and,
        alu_or,
        alu_xor,
        alu_slt,                              // signed compare
        alu_sll,                              // rt shifted by shamt
        alu_lui,                              // imm into upper half
        alu_none                              // no result, branches and unknown ops
    } alu_op_t;

    typedef enum logic [1:0] {
        br_none,
        br_beq,
        br_bne
    } branch_t;

    typedef struct packed {
        logic                      valid;
        logic [`MINI_CPU_XLEN-1:0] pc;
        logic [31:0]               inst;
    } if_id_t;

    typedef struct packed {
        logic                      valid;
        logic [`MINI_CPU_XLEN-1:0] pc;
        alu_op_t                   alu_op;
        logic [4:0]                rs;
        logic [4:0]                rt;
        logic [`MINI_CPU_XLEN-1:0] rs_val;
        logic [`MINI_CPU_XLEN-1:0] rt_val;
        logic [`MINI_CPU_XLEN-1:0] imm32;    // extended imm, or branch offset
        logic                      use_imm;
        logic [4:0]                shamt;
        logic [4:0]                dst;
        logic                      rf_wr;    // never set for dst zero
        branch_t                   branch;
    } id_exe_t;

    typedef struct packed {
        logic                      valid;
        logic [`MINI_CPU_XLEN-1:0] pc;
        logic [4:0]                dst;
        logic                      rf_wr;
        logic [`MINI_CPU_XLEN-1:0] result;
    } exe_wb_t;

    typedef struct packed {
        logic                      taken;
        logic [`MINI_CPU_XLEN-1:0] target;
    } redirect_t;

endpackage

// ==== source/mini_cpu_config.svh ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// mini_cpu configuration
// reset vector and datapath width
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`ifndef MINI_CPU_CONFIG_SVH
`define MINI_CPU_CONFIG_SVH

// first fetch address after reset, kseg1 boot vector
`define MINI_CPU_RESET_PC 32'hbfc0_0000

// data and address width
`define MINI_CPU_XLEN 32

`endif
